//--- verilog.f
+incdir+source
source/dot_pkg.sv
source/fp_mult_pipe.sv
source/vec_mem.sv
source/dot_seq.sv
source/dot_top.sv
bench/dot_props.sv
bench/dot_tb.sv

//--- Makefile
# Verilator build and run of the dot-product accelerator testbench

VERILATOR ?= verilator
TOP       ?= dot_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= STATUS: PASS

SOURCES := $(shell grep -v '^+' $(FILELIST)) source/dot_cfg.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_TEXT"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- bench/dot_tb.sv
// ---------------------------------------------------------------------
// Testbench for the dot-product accelerator
// Clock and reset, channel tasks, reference model, compare tasks,
// directed tests and a cycle-count timeout
// ---------------------------------------------------------------------
`timescale 1ns/100ps
`include "dot_cfg.svh"

module dot_tb;
  import dot_pkg::*;

  localparam int HALF_PERIOD = 20;
  localparam int DRIVE_DELAY = 2;
  // About 110 writes of one cycle and 8 commands of at most 35 cycles,
  // so the limit leaves a wide margin
  localparam int CYCLE_LIMIT = 4000;

  logic    clk;
  logic    reset;
  logic    wr_valid;
  logic    wr_ready;
  wr_req_t wr;
  logic    cmd_valid;
  logic    cmd_ready;
  cmd_t    cmd;
  logic    res_valid;
  logic    res_ready;
  res_t    res;

  // Operand values as the bench has written them
  fix_t   a_vals [`DOT_DEPTH];
  fix_t   b_vals [`DOT_DEPTH];
  integer seed;
  int     errors;
  int     checks;
  int     cycle_count;

  dot_top uut (
    .clk       (clk),
    .reset     (reset),
    .wr_valid  (wr_valid),
    .wr_ready  (wr_ready),
    .wr        (wr),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd       (cmd),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res       (res)
  );

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the tests did not finish within %0d clock cycles", CYCLE_LIMIT);
    $display("STATUS: FAIL");
    $finish;
  end

  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic check_bit(input string name, input string what, input logic expected,
                           input logic actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %s %s: expected %b, actual %b", name, what, expected, actual);
    end
  endtask

  task automatic check_res(input string name, input res_t expected, input res_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %s: expected sum %0d (%h), actual sum %0d (%h)", name,
               expected.sum, expected.sum, actual.sum, actual.sum);
    end
  endtask

  // Products floor to Q8.8 and add into a sum that wraps at 32 bits
  function automatic acc_t model_dot_sum(input int len);
    acc_t sum;
    int   prod;
    fix_t term;
    sum = '0;
    for (int i = 0; i < len; i++) begin
      prod = int'(a_vals[i]) * int'(b_vals[i]);
      term = fix_t'(prod >>> (`DOT_WIDTH - `DOT_INT_WIDTH));
      sum  = sum + acc_t'(term);
    end
    return sum;
  endfunction

  task automatic offer_write(input logic bank, input addr_t addr, input fix_t data);
    wr_valid = 1'b1;
    wr.bank  = bank;
    wr.addr  = addr;
    wr.data  = data;
  endtask

  task automatic finish_write();
    while (!wr_ready) begin
      next_cycle();
    end
    next_cycle();
    wr_valid = 1'b0;
  endtask

  task automatic write_elem(input logic bank, input addr_t addr, input fix_t data);
    offer_write(bank, addr, data);
    finish_write();
    if (bank == BANK_A) begin
      a_vals[addr] = data;
    end else begin
      b_vals[addr] = data;
    end
  endtask

  task automatic load_random();
    for (int i = 0; i < `DOT_DEPTH; i++) begin
      write_elem(BANK_A, addr_t'(i), fix_t'($random(seed)));
      write_elem(BANK_B, addr_t'(i), fix_t'($random(seed)));
    end
  endtask

  task automatic send_cmd(input int len);
    cmd_valid = 1'b1;
    cmd.len   = len_t'(len);
    while (!cmd_ready) begin
      next_cycle();
    end
    next_cycle();
    cmd_valid = 1'b0;
  endtask

  // res_valid must rise exactly lat cycles after the command handshake
  task automatic wait_result(input string name, input int lat);
    int waited;
    waited = 0;
    while (!res_valid) begin
      next_cycle();
      waited++;
      check_bit(name, "res_valid", waited == lat, res_valid);
      check_bit(name, "cmd_ready", 1'b0, cmd_ready);
      check_bit(name, "wr_ready", 1'b0, wr_ready);
    end
  endtask

  // Stalls for the given cycles, then takes the result
  task automatic take_result(input string name, input acc_t expected, input int stall);
    res_t held;
    res_t want;
    held     = res;
    want.sum = expected;
    for (int i = 0; i < stall; i++) begin
      next_cycle();
      check_res({name, " held"}, held, res);
      check_bit(name, "res_valid", 1'b1, res_valid);
      check_bit(name, "cmd_ready", 1'b0, cmd_ready);
      check_bit(name, "wr_ready", 1'b0, wr_ready);
    end
    res_ready = 1'b1;
    next_cycle();
    res_ready = 1'b0;
    check_res(name, want, held);
    check_bit(name, "res_valid after take", 1'b0, res_valid);
  endtask

  task automatic run_dot(input string name, input int len, input acc_t expected,
                         input int stall);
    send_cmd(len);
    wait_result(name, (len == 0) ? 1 : len + 4);
    take_result(name, expected, stall);
  endtask

  task automatic test_single();
    // 1.5 times -2.25
    write_elem(BANK_A, 4'd0, 16'sh0180);
    write_elem(BANK_B, 4'd0, 16'shfdc0);
    run_dot("single", 1, -32'sd864, 0);
  endtask

  task automatic test_truncation();
    write_elem(BANK_A, 4'd0, -16'sd1);
    write_elem(BANK_B, 4'd0, 16'sd128);
    write_elem(BANK_A, 4'd1, -16'sd1);
    write_elem(BANK_B, 4'd1, 16'sd128);
    write_elem(BANK_A, 4'd2, 16'sd1);
    write_elem(BANK_B, 4'd2, 16'sd128);
    write_elem(BANK_A, 4'd3, -16'sd3);
    write_elem(BANK_B, 4'd3, 16'sd200);
    // Terms floor to -1, -1, 0 and -3 in units of 1/256
    run_dot("truncation", 4, -32'sd5, 0);
  endtask

  task automatic test_lengths();
    run_dot("zero length", 0, '0, 0);
    load_random();
    run_dot("partial length", 5, model_dot_sum(5), 0);
  endtask

  task automatic test_write_hold();
    fix_t new_a;
    acc_t old_sum;
    // The held-off write targets a[2], the last element read
    write_elem(BANK_B, 4'd2, 16'sh0200);
    new_a   = a_vals[2] + 16'sh0100;
    old_sum = model_dot_sum(3);
    send_cmd(3);
    offer_write(BANK_A, 4'd2, new_a);
    wait_result("write hold", 7);
    take_result("write hold", old_sum, 2);
    finish_write();
    a_vals[2] = new_a;
    run_dot("write after hold", 3, model_dot_sum(3), 0);
  endtask

  initial begin
    seed      = 32'hd457;
    errors    = 0;
    checks    = 0;
    reset     = 1'b1;
    wr_valid  = 1'b0;
    wr        = '0;
    cmd_valid = 1'b0;
    cmd       = '0;
    res_ready = 1'b0;
    repeat (3) @(posedge clk);
    #DRIVE_DELAY;
    reset = 1'b0;
    check_bit("reset", "res_valid", 1'b0, res_valid);
    check_bit("reset", "cmd_ready", 1'b1, cmd_ready);
    check_bit("reset", "wr_ready", 1'b1, wr_ready);

    test_single();
    load_random();
    run_dot("full vectors", 16, model_dot_sum(16), 0);
    test_truncation();
    load_random();
    run_dot("back-pressure", 16, model_dot_sum(16), 10);
    test_lengths();
    test_write_hold();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- bench/dot_props.sv
// ---------------------------------------------------------------------
// Concurrent assertions on the dot_top handshakes, reset and the
// multiplier latency, bound into dot_top
// ---------------------------------------------------------------------
`timescale 1ns/100ps
`include "dot_cfg.svh"

module dot_props (
  input logic          clk,
  input logic          reset,
  input logic          cmd_ready,
  input logic          wr_ready,
  input logic          res_valid,
  input logic          res_ready,
  input dot_pkg::res_t res,
  input logic          go,
  input logic          done
);

  // Result slot is empty once reset has been applied
  res_after_reset: assert property (@(posedge clk) reset |=> !res_valid)
    else $error("res_valid high after reset");

  // Result may not change while the host stalls
  res_held: assert property (@(posedge clk) disable iff (reset)
    res_valid && !res_ready |=> $stable(res))
    else $error("res changed while res_ready was low");

  // No new command or write while a result waits
  ready_closed: assert property (@(posedge clk) disable iff (reset)
    res_valid |-> !cmd_ready && !wr_ready)
    else $error("cmd_ready or wr_ready high with res_valid");

  // Every go returns its own done after the pipeline latency
  mult_latency: assert property (@(posedge clk) disable iff (reset)
    done == $past(go, `DOT_MULT_LAT))
    else $error("multiplier done does not follow go by its latency");

endmodule

bind dot_top dot_props props (
  .clk       (clk),
  .reset     (reset),
  .cmd_ready (cmd_ready),
  .wr_ready  (wr_ready),
  .res_valid (res_valid),
  .res_ready (res_ready),
  .res       (res),
  .go        (go),
  .done      (done)
);

//--- source/dot_top.sv
// ---------------------------------------------------------------------
// Dot-product accelerator top level
// Two operand memories, command sequencer and pipelined multiplier
// ---------------------------------------------------------------------
`timescale 1ns/100ps

module dot_top (
  input  logic             clk,
  input  logic             reset,
  input  logic             wr_valid,
  output logic             wr_ready,
  input  dot_pkg::wr_req_t wr,
  input  logic             cmd_valid,
  output logic             cmd_ready,
  input  dot_pkg::cmd_t    cmd,
  output logic             res_valid,
  input  logic             res_ready,
  output dot_pkg::res_t    res
);
  import dot_pkg::*;

  logic  idle;
  logic  wr_fire;
  logic  we_a;
  logic  we_b;
  logic  go;
  logic  done;
  addr_t read_addr;
  fix_t  read_a;
  fix_t  read_b;
  fix_t  left;
  fix_t  right;
  fix_t  product;

  // Writes are only taken between commands
  assign wr_ready = idle;
  assign wr_fire  = wr_valid && wr_ready;
  assign we_a     = wr_fire && (wr.bank == BANK_A);
  assign we_b     = wr_fire && (wr.bank == BANK_B);

  vec_mem mem_a (
    .clk        (clk),
    .write_en   (we_a),
    .write_addr (wr.addr),
    .write_data (wr.data),
    .read_addr  (read_addr),
    .read_data  (read_a)
  );

  vec_mem mem_b (
    .clk        (clk),
    .write_en   (we_b),
    .write_addr (wr.addr),
    .write_data (wr.data),
    .read_addr  (read_addr),
    .read_data  (read_b)
  );

  dot_seq seq (
    .clk       (clk),
    .reset     (reset),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd       (cmd),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res       (res),
    .idle      (idle),
    .read_addr (read_addr),
    .read_a    (read_a),
    .read_b    (read_b),
    .go        (go),
    .left      (left),
    .right     (right),
    .done      (done),
    .product   (product)
  );

  fp_mult_pipe mult (
    .clk   (clk),
    .reset (reset),
    .go    (go),
    .left  (left),
    .right (right),
    .out   (product),
    .done  (done)
  );

endmodule

//--- source/dot_seq.sv
// ---------------------------------------------------------------------
// Dot-product command sequencer
// Issues element reads, feeds the multiplier, accumulates products
// and holds the sum on the result channel until it is taken
// ---------------------------------------------------------------------
`timescale 1ns/100ps
`include "dot_cfg.svh"

module dot_seq (
  input  logic           clk,
  input  logic           reset,
  input  logic           cmd_valid,
  output logic           cmd_ready,
  input  dot_pkg::cmd_t  cmd,
  output logic           res_valid,
  input  logic           res_ready,
  output dot_pkg::res_t  res,
  output logic           idle,
  output dot_pkg::addr_t read_addr,
  input  dot_pkg::fix_t  read_a,
  input  dot_pkg::fix_t  read_b,
  output logic           go,
  output dot_pkg::fix_t  left,
  output dot_pkg::fix_t  right,
  input  logic           done,
  input  dot_pkg::fix_t  product
);
  import dot_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    DRAIN,
    HOLD
  } state_t;

  state_t state;
  len_t   len_q;
  len_t   done_cnt;
  addr_t  addr_q;
  logic   issue_q;
  logic   cmd_fire;
  logic   last_addr;
  logic   finish;
  acc_t   acc_q;
  acc_t   product_ext;

  assign idle      = (state == IDLE);
  assign cmd_ready = idle;
  assign res_valid = (state == HOLD);
  assign cmd_fire  = cmd_valid && idle;
  assign read_addr = addr_q;
  assign last_addr = ({1'b0, addr_q} == len_q - 1'b1);
  assign finish    = (state == DRAIN) && (done_cnt == len_q);

  // Memory data lags the address by one cycle, so go lags issue
  assign go    = issue_q;
  assign left  = read_a;
  assign right = read_b;

  assign product_ext = {{(`DOT_ACC_WIDTH-`DOT_WIDTH){product[`DOT_WIDTH-1]}}, product};

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= IDLE;
      addr_q  <= '0;
      issue_q <= 1'b0;
    end else begin
      issue_q <= (state == ISSUE);
      case (state)
        IDLE: begin
          if (cmd_valid) begin
            addr_q <= '0;
            // Zero length skips straight to the drain check
            state  <= (cmd.len == '0) ? DRAIN : ISSUE;
          end
        end
        ISSUE: begin
          addr_q <= addr_q + 1'b1;
          if (last_addr) begin
            state <= DRAIN;
          end
        end
        DRAIN: begin
          if (finish) begin
            state <= HOLD;
          end
        end
        HOLD: begin
          if (res_ready) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Completed products of the current command
  always_ff @(posedge clk) begin
    if (reset) begin
      done_cnt <= '0;
    end else if (cmd_fire) begin
      done_cnt <= '0;
    end else if (done) begin
      done_cnt <= done_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_fire) begin
      len_q <= cmd.len;
      acc_q <= '0;
    end else if (done) begin
      acc_q <= acc_q + product_ext;
    end
    // Sum stays put through HOLD
    if (finish) begin
      res.sum <= acc_q;
    end
  end

endmodule

//--- source/vec_mem.sv
// ---------------------------------------------------------------------
// Operand vector memory
// Synchronous write port, registered read port
// ---------------------------------------------------------------------
`timescale 1ns/100ps
`include "dot_cfg.svh"

module vec_mem (
  input  logic           clk,
  input  logic           write_en,
  input  dot_pkg::addr_t write_addr,
  input  dot_pkg::fix_t  write_data,
  input  dot_pkg::addr_t read_addr,
  output dot_pkg::fix_t  read_data
);
  import dot_pkg::*;

  fix_t mem [`DOT_DEPTH];

  always_ff @(posedge clk) begin
    if (write_en) begin
      mem[write_addr] <= write_data;
    end
  end

  // Read data appears one cycle after the address
  always_ff @(posedge clk) begin
    read_data <= mem[read_addr];
  end

endmodule

//--- source/fp_mult_pipe.sv
// ---------------------------------------------------------------------
// Two-stage pipelined signed fixed-point multiplier
// One go per cycle, each go returns its own done two cycles later
// ---------------------------------------------------------------------
`timescale 1ns/100ps
`include "dot_cfg.svh"

module fp_mult_pipe (
  input  logic          clk,
  input  logic          reset,
  input  logic          go,
  input  dot_pkg::fix_t left,
  input  dot_pkg::fix_t right,
  output dot_pkg::fix_t out,
  output logic          done
);
  import dot_pkg::*;

  localparam int PROD_WIDTH = 2 * `DOT_WIDTH;
  localparam int FRAC_WIDTH = `DOT_WIDTH - `DOT_INT_WIDTH;

  fix_t                         left_q;
  fix_t                         right_q;
  logic signed [PROD_WIDTH-1:0] prod_q;
  logic [`DOT_MULT_LAT-1:0]     valid_q;

  // Valid bits walk alongside the data stages
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[`DOT_MULT_LAT-2:0], go};
    end
  end

  // Stage one, operand registers
  always_ff @(posedge clk) begin
    if (go) begin
      left_q  <= left;
      right_q <= right;
    end
  end

  // Stage two, full-width product of sign-extended operands
  always_ff @(posedge clk) begin
    if (valid_q[0]) begin
      prod_q <= PROD_WIDTH'(left_q) * PROD_WIDTH'(right_q);
    end
  end

  // Dropping the low fraction bits rounds toward minus infinity
  assign out  = prod_q[PROD_WIDTH-`DOT_INT_WIDTH-1:FRAC_WIDTH];
  assign done = valid_q[`DOT_MULT_LAT-1];

endmodule

//--- source/dot_pkg.sv
// ---------------------------------------------------------------------
// Number types and channel structs of the dot-product accelerator
// ---------------------------------------------------------------------
`include "dot_cfg.svh"

package dot_pkg;

  // Signed Q8.8 operand
  typedef logic signed [`DOT_WIDTH-1:0] fix_t;

  // Signed Q24.8 accumulator
  typedef logic signed [`DOT_ACC_WIDTH-1:0] acc_t;

  typedef logic [$clog2(`DOT_DEPTH)-1:0] addr_t;

  // Command length, 0 up to DOT_DEPTH inclusive
  typedef logic [$clog2(`DOT_DEPTH+1)-1:0] len_t;

  // Write bank select
  localparam logic BANK_A = 1'b0;
  localparam logic BANK_B = 1'b1;

  typedef struct packed {
    logic  bank;
    addr_t addr;
    fix_t  data;
  } wr_req_t;

  typedef struct packed {
    len_t len;
  } cmd_t;

  typedef struct packed {
    acc_t sum;
  } res_t;

endpackage

//--- source/dot_cfg.svh
// ---------------------------------------------------------------------
// Fixed-point widths, vector depth and multiplier latency
// ---------------------------------------------------------------------
`ifndef DOT_CFG_SVH
`define DOT_CFG_SVH

// Signed Q8.8 operands
`define DOT_WIDTH     16
`define DOT_INT_WIDTH 8

// Accumulator and result, Q24.8, wraps modulo 2**32
`define DOT_ACC_WIDTH 32

// Elements per operand vector
`define DOT_DEPTH     16

// Cycles from go to done
`define DOT_MULT_LAT  2

`endif
